/* src/memSysPkg.sv */
// Shared widths and enums for the cached data memory system.
// Every RTL file refers to these by scoped name, memSysPkg::name.
package memSysPkg;

    parameter int addrW       = 16; // Host and memory word address
    parameter int dataW       = 16;
    parameter int tagW        = 5;
    parameter int indexW      = 8;  // 256 cache lines
    parameter int offsetW     = 3;  // Byte offset, four words per line
    parameter int numBanks    = 4;
    parameter int readLatency = 2;  // Issue cycle to data cycle

    // Controller states
    typedef enum logic [3:0] {
        stIdle,
        stCompare,
        stAlloc0,   // Line fill, reads go out in 0..3
        stAlloc1,
        stAlloc2,   // Fill words land in 2..5
        stAlloc3,
        stAlloc4,
        stAlloc5,
        stWb0,      // Victim writeback, one word per state
        stWb1,
        stWb2,
        stWb3,
        stDrain     // Wait for all banks idle
    } ctrlState_e;

    // Memory bus opcodes
    typedef enum logic [1:0] {
        memNop,
        memRead,
        memWrite
    } memOp_e;

endpackage

/* src/cacheBus.sv */
// One cache array access between the controller and the cache array.
// Outputs of the array are combinational from the current request.
// A write takes effect on the next rising clock edge.
interface cacheBus;

    logic [memSysPkg::tagW-1:0]    tag;
    logic [memSysPkg::indexW-1:0]  index;
    logic [memSysPkg::offsetW-1:0] offset;
    logic [memSysPkg::dataW-1:0]   wrData;
    logic                          comp;    // Compare mode
    logic                          write;
    logic                          validIn;

    logic [memSysPkg::dataW-1:0]   rdData;
    logic [memSysPkg::tagW-1:0]    tagOut;  // Stored tag of the line
    logic                          hit;
    logic                          dirty;
    logic                          valid;
    logic                          err;

    modport ctrl (output tag, index, offset, wrData, comp, write, validIn,
                  input  rdData, tagOut, hit, dirty, valid, err);

    modport array (input  tag, index, offset, wrData, comp, write, validIn,
                   output rdData, tagOut, hit, dirty, valid, err);

endinterface

/* src/memBus.sv */
// One word access between the controller and the banked main memory.
// An op is taken at a rising edge while stall is low; stall follows
// the busy bit of the bank that addr selects.
interface memBus;

    logic [memSysPkg::addrW-1:0]    addr;
    logic [memSysPkg::dataW-1:0]    wrData;
    memSysPkg::memOp_e              op;

    logic [memSysPkg::dataW-1:0]    rdData;
    logic                           stall;
    logic [memSysPkg::numBanks-1:0] busy;  // One bit per bank
    logic                           err;   // Misaligned op, one cycle

    modport ctrl (output addr, wrData, op,
                  input  rdData, stall, busy, err);

    modport mem (input  addr, wrData, op,
                 output rdData, stall, busy, err);

endinterface

/* src/cacheArray.sv */
// Direct-mapped cache storage: valid, dirty, tag and four data words per line.
// Compare mode checks the tag and writes only on a hit, marking the line dirty.
// Access mode reads or fills a word, storing the tag and clearing dirty.
// Reads are combinational; writes land on the rising edge.
module cacheArray (
    input  logic   clk,
    input  logic   rstN,
    cacheBus.array cache
);

    localparam int numLines     = 1 << memSysPkg::indexW;
    localparam int wordsPerLine = 1 << (memSysPkg::offsetW - 1);

    logic [numLines-1:0]            validBits;
    logic [numLines-1:0]            dirtyBits;
    logic [memSysPkg::tagW-1:0]     tagMem  [numLines];
    logic [memSysPkg::dataW-1:0]    dataMem [numLines][wordsPerLine];

    logic [memSysPkg::offsetW-2:0]  wordSel;
    logic                           lineValid;
    logic                           tagMatch;
    logic                           doWrite;

    assign wordSel   = cache.offset[memSysPkg::offsetW-1:1]; // Bit 0 is the byte lane
    assign lineValid = validBits[cache.index];
    assign tagMatch  = (tagMem[cache.index] == cache.tag);

    // Lookup side
    assign cache.rdData = dataMem[cache.index][wordSel];
    assign cache.tagOut = tagMem[cache.index];
    assign cache.valid  = lineValid;
    assign cache.dirty  = dirtyBits[cache.index];
    assign cache.hit    = cache.comp & lineValid & tagMatch;

    // Odd offset on a compare or a write
    assign cache.err = cache.offset[0] & (cache.comp | cache.write);

    // A compare write that misses leaves the line alone
    assign doWrite = cache.write & (~cache.comp | cache.hit);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            validBits <= '0;
        end else if (doWrite && !cache.comp) begin
            validBits[cache.index] <= cache.validIn;
        end
    end

    always_ff @(posedge clk) begin
        if (doWrite) begin
            dataMem[cache.index][wordSel] <= cache.wrData;
            tagMem[cache.index]           <= cache.tag;  // Unchanged on a compare hit
            dirtyBits[cache.index]        <= cache.comp; // Host write dirties, fill cleans
        end
    end

endmodule

/* src/bankedMemory.sv */
// Four-bank interleaved main memory of 32K words, bank chosen by addr[2:1].
// Each access holds its bank busy for bankBusyCycles cycles, and a new op to
// a busy bank is held off with stall. Read data comes back through a short
// pipeline, readLatency cycles after the cycle the read is issued, so reads
// to different banks can be in flight together.
module bankedMemory #(
    parameter int bankBusyCycles = 4 // 1 to 4
) (
    input  logic clk,
    input  logic rstN,
    memBus.mem   mem
);

    localparam int bankSelW  = $clog2(memSysPkg::numBanks);
    localparam int rowW      = memSysPkg::addrW - bankSelW - 1;
    localparam int bankWords = 1 << rowW;
    localparam int cntW      = $clog2(bankBusyCycles + 1);

    // Contents start at zero
    logic [memSysPkg::dataW-1:0] bankMem [memSysPkg::numBanks][bankWords] =
        '{default: '0};

    logic [memSysPkg::dataW-1:0] readPipe [memSysPkg::readLatency];
    logic [cntW-1:0]             busyCnt  [memSysPkg::numBanks];

    logic [bankSelW-1:0] bankSel;
    logic [rowW-1:0]     row;
    logic                accept;
    logic                errReg;

    assign bankSel = mem.addr[bankSelW:1];
    assign row     = mem.addr[memSysPkg::addrW-1:bankSelW+1];

    assign mem.stall = mem.busy[bankSel];
    assign accept    = (mem.op != memSysPkg::memNop) & ~mem.stall;

    for (genvar b = 0; b < memSysPkg::numBanks; b++) begin : gBusy
        assign mem.busy[b] = (busyCnt[b] != '0);
    end

    // Per-bank busy timers
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int b = 0; b < memSysPkg::numBanks; b++) begin
                busyCnt[b] <= '0;
            end
        end else begin
            for (int b = 0; b < memSysPkg::numBanks; b++) begin
                if (accept && bankSel == bankSelW'(b)) begin
                    busyCnt[b] <= cntW'(bankBusyCycles);
                end else if (busyCnt[b] != '0) begin
                    busyCnt[b] <= busyCnt[b] - 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            errReg <= 1'b0;
        end else begin
            errReg <= accept & mem.addr[0]; // Word ops must be aligned
        end
    end

    assign mem.err = errReg;

    always_ff @(posedge clk) begin
        if (accept && mem.op == memSysPkg::memWrite) begin
            bankMem[bankSel][row] <= mem.wrData;
        end
    end

    // Read data pipeline
    always_ff @(posedge clk) begin
        if (accept && mem.op == memSysPkg::memRead) begin
            readPipe[0] <= bankMem[bankSel][row];
        end
        for (int i = 1; i < memSysPkg::readLatency; i++) begin
            readPipe[i] <= readPipe[i-1];
        end
    end

    assign mem.rdData = readPipe[memSysPkg::readLatency-1];

endmodule

/* src/cacheCtrl.sv */
// Cache controller: captures one host request in idle, looks it up in the
// cache, and on a miss writes back a dirty victim and refills the line from
// main memory before repeating the compare. Done and DataOut come out of
// the final compare cycle.
module cacheCtrl (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [memSysPkg::addrW-1:0] addr,
    input  logic [memSysPkg::dataW-1:0] dataIn,
    input  logic                        rd,
    input  logic                        wr,
    output logic [memSysPkg::dataW-1:0] dataOut,
    output logic                        done,
    output logic                        stall,
    output logic                        cacheHit,
    output logic                        err,
    cacheBus.ctrl                       cache,
    memBus.ctrl                         mem
);

    localparam int tagLsb = memSysPkg::indexW + memSysPkg::offsetW;

    memSysPkg::ctrlState_e state, nextState;

    logic [memSysPkg::addrW-1:0]   reqAddr;
    logic [memSysPkg::dataW-1:0]   reqData;
    logic                          reqWr;
    logic                          missFlag;  // Any failed compare for this request
    logic                          lineHit;
    logic                          request;

    logic [memSysPkg::tagW-1:0]    reqTag;
    logic [memSysPkg::indexW-1:0]  reqIndex;
    logic [memSysPkg::offsetW-1:0] cacheOff;
    logic [memSysPkg::offsetW-1:0] memOff;
    memSysPkg::memOp_e             memOp;
    logic                          fill;      // Refill word goes into the cache
    logic                          writeBack;

    assign request  = (state == memSysPkg::stIdle) & (rd | wr);
    assign lineHit  = cache.hit & cache.valid;
    assign reqTag   = reqAddr[memSysPkg::addrW-1:tagLsb];
    assign reqIndex = reqAddr[tagLsb-1:memSysPkg::offsetW];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state <= memSysPkg::stIdle;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            reqWr <= 1'b0;
        end else if (request) begin
            reqWr <= wr;
        end
    end

    always_ff @(posedge clk) begin
        if (request) begin
            reqAddr <= addr;
            reqData <= dataIn;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            missFlag <= 1'b0;
        end else if (state == memSysPkg::stIdle) begin
            missFlag <= 1'b0;
        end else if (state == memSysPkg::stCompare && !lineHit) begin
            missFlag <= 1'b1;
        end
    end

    always_comb begin
        nextState = state;
        unique case (state)
            memSysPkg::stIdle:    if (rd || wr) nextState = memSysPkg::stCompare;
            memSysPkg::stCompare: begin
                if (lineHit) begin
                    nextState = memSysPkg::stIdle;
                end else if (cache.valid && cache.dirty) begin
                    nextState = memSysPkg::stWb0;   // Dirty victim goes out first
                end else begin
                    nextState = memSysPkg::stAlloc0;
                end
            end
            memSysPkg::stAlloc0:  nextState = memSysPkg::stAlloc1;
            memSysPkg::stAlloc1:  nextState = memSysPkg::stAlloc2;
            memSysPkg::stAlloc2:  nextState = memSysPkg::stAlloc3;
            memSysPkg::stAlloc3:  nextState = memSysPkg::stAlloc4;
            memSysPkg::stAlloc4:  nextState = memSysPkg::stAlloc5;
            memSysPkg::stAlloc5:  nextState = memSysPkg::stCompare;
            memSysPkg::stWb0:     if (!mem.stall) nextState = memSysPkg::stWb1;
            memSysPkg::stWb1:     if (!mem.stall) nextState = memSysPkg::stWb2;
            memSysPkg::stWb2:     if (!mem.stall) nextState = memSysPkg::stWb3;
            memSysPkg::stWb3:     if (!mem.stall) nextState = memSysPkg::stDrain;
            memSysPkg::stDrain:   if (mem.busy == '0) nextState = memSysPkg::stAlloc0;
            default:              nextState = memSysPkg::stIdle;
        endcase
    end

    // Per-state offsets and memory op
    always_comb begin
        cacheOff  = 3'd0;
        memOff    = 3'd0;
        memOp     = memSysPkg::memNop;
        fill      = 1'b0;
        writeBack = 1'b0;
        unique case (state)
            memSysPkg::stCompare: cacheOff = reqAddr[memSysPkg::offsetW-1:0];
            memSysPkg::stAlloc0: begin
                memOp = memSysPkg::memRead;
            end
            memSysPkg::stAlloc1: begin
                memOp  = memSysPkg::memRead;
                memOff = 3'd2;
            end
            memSysPkg::stAlloc2: begin
                memOp  = memSysPkg::memRead;
                memOff = 3'd4;
                fill   = 1'b1;   // Word 0 is back
            end
            memSysPkg::stAlloc3: begin
                memOp    = memSysPkg::memRead;
                memOff   = 3'd6;
                cacheOff = 3'd2;
                fill     = 1'b1;
            end
            memSysPkg::stAlloc4: begin
                cacheOff = 3'd4;
                fill     = 1'b1;
            end
            memSysPkg::stAlloc5: begin
                cacheOff = 3'd6;
                fill     = 1'b1;
            end
            memSysPkg::stWb0, memSysPkg::stWb1, memSysPkg::stWb2, memSysPkg::stWb3: begin
                memOp     = memSysPkg::memWrite;
                writeBack = 1'b1;
                cacheOff  = 3'(state - memSysPkg::stWb0) << 1; // 0, 2, 4, 6
                memOff    = cacheOff;
            end
            default: ;
        endcase
    end

    assign cache.tag     = reqTag;
    assign cache.index   = reqIndex;
    assign cache.offset  = cacheOff;
    assign cache.wrData  = fill ? mem.rdData : reqData;
    assign cache.comp    = (state == memSysPkg::stCompare);
    assign cache.write   = fill | (cache.comp & reqWr);
    assign cache.validIn = fill;

    // Victim lines go back under their own stored tag
    assign mem.addr   = {writeBack ? cache.tagOut : reqTag, reqIndex, memOff};
    assign mem.wrData = cache.rdData;
    assign mem.op     = memOp;

    assign done     = cache.comp & lineHit;
    assign cacheHit = done & ~missFlag;   // Hit on the first compare only
    assign dataOut  = cache.rdData;
    assign stall    = (state == memSysPkg::stIdle) ? (rd | wr) : ~done;
    assign err      = cache.err | mem.err;

endmodule

/* src/memSystem.sv */
// Top level of the cached data memory system.
// The host drives Addr, DataIn and Rd or Wr for one request at a time and
// waits while Stall is high; Done marks the end, with DataOut and CacheHit.
// err flags a misaligned access from the cache or the main memory.
module memSystem #(
    parameter int bankBusyCycles = 4 // Bank recovery time, 1 to 4
) (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic [memSysPkg::addrW-1:0] Addr,
    input  logic [memSysPkg::dataW-1:0] DataIn,
    input  logic                        Rd,
    input  logic                        Wr,
    output logic [memSysPkg::dataW-1:0] DataOut,
    output logic                        Done,
    output logic                        Stall,
    output logic                        CacheHit,
    output logic                        err
);

    cacheBus cacheIf ();
    memBus   memIf ();

    cacheCtrl iCtrl (
        .clk      (clk),
        .rstN     (rstN),
        .addr     (Addr),
        .dataIn   (DataIn),
        .rd       (Rd),
        .wr       (Wr),
        .dataOut  (DataOut),
        .done     (Done),
        .stall    (Stall),
        .cacheHit (CacheHit),
        .err      (err),        // Cache and memory errors combined
        .cache    (cacheIf.ctrl),
        .mem      (memIf.ctrl)
    );

    cacheArray iArray (
        .clk   (clk),
        .rstN  (rstN),
        .cache (cacheIf.array)
    );

    bankedMemory #(
        .bankBusyCycles (bankBusyCycles)
    ) iMem (
        .clk  (clk),
        .rstN (rstN),
        .mem  (memIf.mem)
    );

endmodule

/* dv/clkGen.sv */
// Clock and reset for the memory system testbench.
// Free-running clock; reset is held low for a number of cycles and
// released on a falling edge.
module clkGen #(
    parameter int periodNs    = 40,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1; // Away from the sampling edge
    end

endmodule

/* dv/memSystemTb.sv */
// Testbench for the cached data memory system.
// Runs a fixed request table and then a pseudo-random mix of reads and writes,
// predicting data, hit, latency and err from a shadow memory and tag store.
// Inputs change on the falling edge; outputs are sampled there too.
module memSystemTb;
    timeunit 1ns;
    timeprecision 1ps;

    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [15:0] addr;
        logic [15:0] data;
    } reqEntry_t;

    localparam int tableLen = 15;
    localparam int randLen  = 24;
    localparam longint watchdogNs = longint'((tableLen + randLen) * 40 + 20) * 40;

    // Address layout: tag 15:11, index 10:3, offset 2:0
    localparam reqEntry_t reqTable [tableLen] = '{
        {1'b1, 1'b0, 16'h0000, 16'h0000},  // First read after reset, clean miss
        {1'b1, 1'b0, 16'h0000, 16'h0000},  // Same line, hit
        {1'b0, 1'b1, 16'h0002, 16'hBEEF},  // Write hit
        {1'b1, 1'b0, 16'h0002, 16'h0000},
        {1'b1, 1'b0, 16'h0124, 16'h0000},  // New index
        {1'b0, 1'b1, 16'h1010, 16'h1234},  // Write miss, line goes dirty
        {1'b1, 1'b0, 16'h3010, 16'h0000},  // Same index, other tag, evicts
        {1'b1, 1'b0, 16'h1010, 16'h0000},  // Refill must bring 1234 back
        {1'b0, 1'b1, 16'h0812, 16'h5A5A},
        {1'b0, 1'b1, 16'h0812, 16'h6B6B},  // Repeated write, hit
        {1'b1, 1'b0, 16'h1016, 16'h0000},  // Dirty victim again
        {1'b1, 1'b0, 16'h0812, 16'h0000},
        {1'b1, 1'b0, 16'h0003, 16'h0000},  // Misaligned read
        {1'b0, 1'b1, 16'h0125, 16'h0F0F},  // Misaligned write
        {1'b1, 1'b0, 16'h0124, 16'h0000}
    };

    logic        clk;
    logic        rstN;
    logic [15:0] Addr;
    logic [15:0] DataIn;
    logic        Rd;
    logic        Wr;
    logic [15:0] DataOut;
    logic        Done;
    logic        Stall;
    logic        CacheHit;
    logic        err;

    // Reference model state
    logic [15:0] shadowMem [32768];   // One entry per 16-bit word
    logic [4:0]  shadowTag [256];
    logic        shadowValid [256];
    logic        shadowDirty [256];
    logic [15:0] lfsr;

    clkGen #(.periodNs(40), .resetCycles(8)) iClkGen (.clk(clk), .rstN(rstN));

    memSystem #(.bankBusyCycles(4)) i_dut (
        .clk      (clk),
        .rstN     (rstN),
        .Addr     (Addr),
        .DataIn   (DataIn),
        .Rd       (Rd),
        .Wr       (Wr),
        .DataOut  (DataOut),
        .Done     (Done),
        .Stall    (Stall),
        .CacheHit (CacheHit),
        .err      (err)
    );

    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit
    function automatic logic [15:0] takeBits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[14:0], lfsr[0]};
            lfsr = lfsrNext(lfsr);
        end
        return v;
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Stopped at the first mismatch");
        end
    endtask

    // Issues one request, waits for Done and checks it against the model
    task automatic runAccess(input logic isRd, input logic isWr,
                             input logic [15:0] reqAddr, input logic [15:0] reqData);
        int          cycles;
        logic        gotDone;
        logic        gotHit;
        logic        errSeen;
        logic [15:0] gotData;
        logic [7:0]  index;
        logic [4:0]  tag;
        logic [14:0] wordAddr;
        logic        expHit;
        logic        expClean;
        logic [15:0] expData;
        index    = reqAddr[10:3];
        tag      = reqAddr[15:11];
        wordAddr = reqAddr[15:1];
        expHit   = shadowValid[index] && (shadowTag[index] == tag);
        expClean = !expHit && !(shadowValid[index] && shadowDirty[index]);
        expData  = shadowMem[wordAddr];

        @(negedge clk);
        Rd     = isRd;
        Wr     = isWr;
        Addr   = reqAddr;
        DataIn = reqData;
        cycles  = 0;
        gotDone = 1'b0;
        errSeen = 1'b0;
        while (!gotDone) begin
            @(negedge clk);
            cycles++;
            gotDone = Done;
            gotHit  = CacheHit;
            gotData = DataOut;
            errSeen = errSeen | err;
            if (gotDone) begin
                checkEq(32'(Stall), 0, $sformatf("Stall with Done at %h", reqAddr));
            end else begin
                checkEq(32'(Stall), 1, $sformatf("Stall before Done at %h", reqAddr));
                checkEq(32'(CacheHit), 0, $sformatf("CacheHit before Done at %h", reqAddr));
            end
            Rd = 1'b0;  // Request is one cycle wide
            Wr = 1'b0;
        end

        checkEq(32'(gotHit), 32'(expHit), $sformatf("CacheHit at %h", reqAddr));
        checkEq(32'(errSeen), 32'(reqAddr[0]), $sformatf("err at %h", reqAddr));
        if (isRd) begin
            checkEq(32'(gotData), 32'(expData), $sformatf("read data at %h", reqAddr));
        end
        if (expHit) begin
            checkEq(cycles, 1, $sformatf("hit latency at %h", reqAddr));
        end else if (expClean) begin
            checkEq(cycles, 8, $sformatf("clean miss latency at %h", reqAddr));
        end

        shadowValid[index] = 1'b1;
        shadowTag[index]   = tag;
        if (isWr) begin
            shadowMem[wordAddr] = reqData;
            shadowDirty[index]  = 1'b1;
        end else if (!expHit) begin
            shadowDirty[index] = 1'b0;  // Fresh refill
        end
    endtask

    initial begin
        #(watchdogNs);
        $display("Watchdog: the DUT stopped responding, no Done within %0d ns", watchdogNs);
        $display("Result: FAILED");
        $fatal(1, "Simulation timed out");
    end

    initial begin
        logic [15:0] rKind;
        logic [15:0] rTag;
        logic [15:0] rIdx;
        logic [15:0] rOff;
        logic [15:0] rData;
        Rd     = 1'b0;
        Wr     = 1'b0;
        Addr   = '0;
        DataIn = '0;
        lfsr   = 16'd24;
        for (int i = 0; i < 32768; i++) begin
            shadowMem[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            shadowTag[i]   = '0;
            shadowValid[i] = 1'b0;
            shadowDirty[i] = 1'b0;
        end

        wait (rstN === 1'b1);
        @(negedge clk);
        checkEq(32'(Stall), 0, "Stall after reset");
        checkEq(32'(Done), 0, "Done after reset");
        checkEq(32'(CacheHit), 0, "CacheHit after reset");
        checkEq(32'(err), 0, "err after reset");

        foreach (reqTable[i]) begin
            runAccess(reqTable[i].rd, reqTable[i].wr, reqTable[i].addr, reqTable[i].data);
        end

        // Few tags and indices so hits, clean and dirty misses all occur
        for (int i = 0; i < randLen; i++) begin
            rKind = takeBits(1);
            rTag  = takeBits(2);
            rIdx  = takeBits(2);
            rOff  = takeBits(2);
            rData = takeBits(16);
            runAccess(!rKind[0], rKind[0],
                      {3'b000, rTag[1:0], 6'b000000, rIdx[1:0], rOff[1:0], 1'b0}, rData);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* sources.f */
src/memSysPkg.sv
src/cacheBus.sv
src/memBus.sv
src/cacheArray.sv
src/bankedMemory.sv
src/cacheCtrl.sv
src/memSystem.sv
dv/clkGen.sv
dv/memSystemTb.sv

/* run.sh */
#!/bin/sh
# Builds the memSystem testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sources.f --top-module memSystemTb -o simv \
    || { echo "Verilator build failed"; exit 1; }
./obj_dir/simv > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Result: PASSED" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
